//--- hw/lc4_isa_pkg.sv
//////////////////////////////////////////////////
// lc4 instruction set definitions
// opcodes, instruction field views, decoded control
//////////////////////////////////////////////////
package lc4_isa_pkg;

    // supported opcode subset, anything else is a no-op
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    // arith sub-op, insn[5:3]
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } nzp_t;

    typedef struct packed {
        opcode_t    op;
        logic [2:0] rd;
        logic [2:0] rs;
        logic       imm_flag;
        logic [1:0] sub;
        logic [2:0] rt;
    } arith_r_t;

    typedef struct packed {
        opcode_t    op;
        logic [2:0] rd;
        logic [2:0] rs;
        logic       imm_flag;
        logic [4:0] imm5;
    } arith_i_t;

    // rd for loads, rt (store data) for stores
    typedef struct packed {
        opcode_t    op;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [5:0] imm6;
    } mem_t;

    typedef struct packed {
        opcode_t    op;
        nzp_t       mask;
        logic [8:0] imm9;
    } br_t;

    typedef struct packed {
        opcode_t    op;
        logic [2:0] rd;
        logic [8:0] imm9;
    } const_t;

    typedef union packed {
        arith_r_t arith_r;
        arith_i_t arith_i;
        mem_t     mem;
        br_t      br;
        const_t   cnst;
    } insn_u;

    typedef struct packed {
        logic rs_re;
        logic rt_re;
        logic rd_we;
        logic nzp_we;
        logic is_load;
        logic is_store;
        logic is_branch;
    } ctrl_t;

endpackage

//--- hw/lc4_pipe_pkg.sv
//////////////////////////////////////////////////
// lc4 pipeline payloads
// data-path width and the stage-to-stage structs
//////////////////////////////////////////////////
package lc4_pipe_pkg;

    localparam int NUM_REGS = 8;

    typedef logic [15:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // decode to execute
    typedef struct packed {
        logic                valid;
        word_t               pc;
        lc4_isa_pkg::insn_u  insn;
        lc4_isa_pkg::ctrl_t  ctrl;
        reg_idx_t            rs;
        reg_idx_t            rt;
        reg_idx_t            rd;
        word_t               rs_val;
        word_t               rt_val;
    } dx_t;

    // execute to memory
    typedef struct packed {
        logic                valid;
        word_t               pc;
        lc4_isa_pkg::insn_u  insn;
        lc4_isa_pkg::ctrl_t  ctrl;
        reg_idx_t            rd;
        reg_idx_t            rt;
        word_t               alu_out;
        word_t               store_val;
    } xm_t;

    // writeback, feeds regfile, WX bypass and trace
    typedef struct packed {
        logic     valid;
        logic     we;
        reg_idx_t rd;
        word_t    data;
        word_t    pc;
    } wb_t;

endpackage

//--- hw/lc4_fetch.sv
//////////////////////////////////////////////////
// lc4 fetch stage
// pc register and next-pc selection
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_fetch #(
    parameter lc4_pipe_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic                gwe,
    input  logic                i_reset,
    input  logic                i_stall,
    input  logic                i_redirect,
    input  lc4_pipe_pkg::word_t i_target,
    output lc4_pipe_pkg::word_t o_pc
);

    lc4_pipe_pkg::word_t pc_q;
    lc4_pipe_pkg::word_t next_pc;

    // redirect beats stall
    always_comb begin
        if (i_redirect) begin
            next_pc = i_target;
        end else if (i_stall) begin
            next_pc = pc_q;
        end else begin
            next_pc = pc_q + 16'd1;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign o_pc = pc_q;

    // a redirect leaves a bubble in X, so fetch steps on by one from the target
    assert property (@(posedge gwe) disable iff (i_reset)
        $past(i_redirect, 2) |-> pc_q == $past(i_target, 2) + 16'd1);

endmodule

//--- hw/lc4_decode.sv
//////////////////////////////////////////////////
// lc4 decode stage
// D register, decode and load-use stall detection
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_decode (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_pipe_pkg::word_t    i_pc,
    input  lc4_pipe_pkg::word_t    i_insn,
    input  logic                   i_flush,
    input  logic                   i_ex_is_load,
    input  lc4_pipe_pkg::reg_idx_t i_ex_rd,
    output logic                   o_stall,
    output lc4_pipe_pkg::reg_idx_t o_rs_idx,
    output lc4_pipe_pkg::reg_idx_t o_rt_idx,
    input  lc4_pipe_pkg::word_t    i_rs_val,
    input  lc4_pipe_pkg::word_t    i_rt_val,
    output lc4_pipe_pkg::dx_t      o_dx
);

    logic                d_valid;
    lc4_pipe_pkg::word_t d_pc;
    lc4_isa_pkg::insn_u  d_insn;
    lc4_isa_pkg::ctrl_t  ctrl;
    logic                rs_hit;
    logic                rt_hit;

    // flush wins over stall
    always_ff @(posedge gwe) begin
        if (i_reset || i_flush) begin
            d_valid <= 1'b0;
        end else if (!o_stall) begin
            d_valid <= 1'b1;
            d_pc    <= i_pc;
            d_insn  <= i_insn;
        end
    end

    always_comb begin
        ctrl     = '0;
        o_rs_idx = d_insn.mem.rs;
        o_rt_idx = d_insn.arith_r.rt;
        if (d_valid) begin
            case (d_insn.br.op)
                lc4_isa_pkg::OP_BR: begin
                    ctrl.is_branch = 1'b1;
                end
                lc4_isa_pkg::OP_ARITH: begin
                    if (d_insn.arith_i.imm_flag) begin
                        ctrl.rs_re  = 1'b1;
                        ctrl.rd_we  = 1'b1;
                        ctrl.nzp_we = 1'b1;
                    end else if ({1'b0, d_insn.arith_r.sub} == lc4_isa_pkg::SUB_ADD ||
                                 {1'b0, d_insn.arith_r.sub} == lc4_isa_pkg::SUB_SUB) begin
                        ctrl.rs_re  = 1'b1;
                        ctrl.rt_re  = 1'b1;
                        ctrl.rd_we  = 1'b1;
                        ctrl.nzp_we = 1'b1;
                    end
                end
                lc4_isa_pkg::OP_LDR: begin
                    ctrl.rs_re   = 1'b1;
                    ctrl.rd_we   = 1'b1;
                    ctrl.nzp_we  = 1'b1;
                    ctrl.is_load = 1'b1;
                end
                lc4_isa_pkg::OP_STR: begin
                    ctrl.rs_re    = 1'b1;
                    ctrl.rt_re    = 1'b1;
                    ctrl.is_store = 1'b1;
                    o_rt_idx      = d_insn.mem.rd;
                end
                lc4_isa_pkg::OP_CONST: begin
                    ctrl.rd_we  = 1'b1;
                    ctrl.nzp_we = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign rs_hit = ctrl.rs_re && (o_rs_idx == i_ex_rd);
    // store data from a load gets the W to M bypass instead
    assign rt_hit = ctrl.rt_re && !ctrl.is_store && (o_rt_idx == i_ex_rd);
    // a branch waits for the load's nzp
    assign o_stall = i_ex_is_load && (rs_hit || rt_hit || ctrl.is_branch);

    always_comb begin
        o_dx.valid  = d_valid && !o_stall && !i_flush;
        o_dx.pc     = d_pc;
        o_dx.insn   = d_insn;
        o_dx.ctrl   = o_dx.valid ? ctrl : '0;
        o_dx.rs     = o_rs_idx;
        o_dx.rt     = o_rt_idx;
        o_dx.rd     = d_insn.mem.rd;
        o_dx.rs_val = i_rs_val;
        o_dx.rt_val = i_rt_val;
    end

    // a stall holds a live D slot for exactly one cycle
    assert property (@(posedge gwe) disable iff (i_reset)
        o_stall |-> d_valid ##1 (d_valid && $stable(d_pc) && !o_stall));

endmodule

//--- hw/lc4_regfile.sv
//////////////////////////////////////////////////
// lc4 register file
// eight registers, write-through on read
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_regfile (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_pipe_pkg::reg_idx_t i_rs_idx,
    input  lc4_pipe_pkg::reg_idx_t i_rt_idx,
    output lc4_pipe_pkg::word_t    o_rs_val,
    output lc4_pipe_pkg::word_t    o_rt_val,
    input  lc4_pipe_pkg::wb_t      i_wb
);

    lc4_pipe_pkg::word_t regs [lc4_pipe_pkg::NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < lc4_pipe_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // same-cycle write is visible to D
    assign o_rs_val = (i_wb.we && i_wb.rd == i_rs_idx) ? i_wb.data : regs[i_rs_idx];
    assign o_rt_val = (i_wb.we && i_wb.rd == i_rt_idx) ? i_wb.data : regs[i_rt_idx];

endmodule

//--- hw/lc4_execute.sv
//////////////////////////////////////////////////
// lc4 execute stage
// X register, bypass, ALU, nzp and branch resolution
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_execute (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_pipe_pkg::dx_t      i_dx,
    input  lc4_pipe_pkg::xm_t      i_mem,
    input  lc4_pipe_pkg::wb_t      i_wb,
    input  logic                   i_load_nzp_we,
    input  lc4_pipe_pkg::word_t    i_load_data,
    output lc4_pipe_pkg::xm_t      o_xm,
    output logic                   o_redirect,
    output lc4_pipe_pkg::word_t    o_target,
    output logic                   o_ex_is_load,
    output lc4_pipe_pkg::reg_idx_t o_ex_rd
);

    lc4_pipe_pkg::dx_t   x_q;
    lc4_isa_pkg::nzp_t   nzp_q;
    lc4_pipe_pkg::word_t rs_op;
    lc4_pipe_pkg::word_t rt_op;
    lc4_pipe_pkg::word_t alu_out;

    function automatic lc4_isa_pkg::nzp_t nzp_of(input lc4_pipe_pkg::word_t v);
        lc4_isa_pkg::nzp_t f;
        f.n = v[15];
        f.z = (v == 16'h0000);
        f.p = !v[15] && (v != 16'h0000);
        return f;
    endfunction

    // M first unless it is a load, then W, then the regfile value
    function automatic lc4_pipe_pkg::word_t bypass(input lc4_pipe_pkg::reg_idx_t idx,
                                                   input lc4_pipe_pkg::word_t rf_val,
                                                   input lc4_pipe_pkg::xm_t m,
                                                   input lc4_pipe_pkg::wb_t w);
        if (m.ctrl.rd_we && !m.ctrl.is_load && m.rd == idx) begin
            return m.alu_out;
        end
        if (w.we && w.rd == idx) begin
            return w.data;
        end
        return rf_val;
    endfunction

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            x_q.valid <= 1'b0;
            x_q.ctrl  <= '0;
        end else begin
            x_q <= i_dx;
        end
    end

    assign rs_op = bypass(x_q.rs, x_q.rs_val, i_mem, i_wb);
    assign rt_op = bypass(x_q.rt, x_q.rt_val, i_mem, i_wb);

    always_comb begin
        case (x_q.insn.br.op)
            lc4_isa_pkg::OP_ARITH: begin
                if (x_q.insn.arith_i.imm_flag) begin
                    alu_out = rs_op + {{11{x_q.insn.arith_i.imm5[4]}}, x_q.insn.arith_i.imm5};
                end else if ({1'b0, x_q.insn.arith_r.sub} == lc4_isa_pkg::SUB_SUB) begin
                    alu_out = rs_op - rt_op;
                end else begin
                    alu_out = rs_op + rt_op;
                end
            end
            lc4_isa_pkg::OP_LDR, lc4_isa_pkg::OP_STR: begin
                alu_out = rs_op + {{10{x_q.insn.mem.imm6[5]}}, x_q.insn.mem.imm6};
            end
            lc4_isa_pkg::OP_CONST: begin
                alu_out = {{7{x_q.insn.cnst.imm9[8]}}, x_q.insn.cnst.imm9};
            end
            lc4_isa_pkg::OP_BR: begin
                alu_out = x_q.pc + 16'd1 + {{7{x_q.insn.br.imm9[8]}}, x_q.insn.br.imm9};
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // X writer is younger than the load in M, so it wins
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_q <= '0;
        end else if (x_q.ctrl.nzp_we && !x_q.ctrl.is_load) begin
            nzp_q <= nzp_of(alu_out);
        end else if (i_load_nzp_we) begin
            nzp_q <= nzp_of(i_load_data);
        end
    end

    assign o_redirect   = x_q.ctrl.is_branch && ((nzp_q & x_q.insn.br.mask) != 3'b000);
    assign o_target     = alu_out;
    assign o_ex_is_load = x_q.ctrl.is_load;
    assign o_ex_rd      = x_q.rd;

    always_comb begin
        o_xm.valid     = x_q.valid;
        o_xm.pc        = x_q.pc;
        o_xm.insn      = x_q.insn;
        o_xm.ctrl      = x_q.ctrl;
        o_xm.rd        = x_q.rd;
        o_xm.rt        = x_q.rt;
        o_xm.alu_out   = alu_out;
        o_xm.store_val = rt_op;
    end

    // a taken branch is live and leaves a bubble behind it in X
    assert property (@(posedge gwe) disable iff (i_reset)
        o_redirect |-> x_q.valid ##1 !x_q.valid);

endmodule

//--- hw/lc4_mem_wb.sv
//////////////////////////////////////////////////
// lc4 memory and writeback stages
// dmem port, store-data bypass, writeback select
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_mem_wb (
    input  logic                gwe,
    input  logic                i_reset,
    input  lc4_pipe_pkg::xm_t   i_xm,
    output lc4_pipe_pkg::xm_t   o_mem,
    input  lc4_pipe_pkg::word_t i_dmem_data,
    output lc4_pipe_pkg::word_t o_dmem_addr,
    output logic                o_dmem_we,
    output lc4_pipe_pkg::word_t o_dmem_towrite,
    output logic                o_load_nzp_we,
    output lc4_pipe_pkg::word_t o_load_data,
    output lc4_pipe_pkg::wb_t   o_wb
);

    lc4_pipe_pkg::xm_t m_q;
    lc4_pipe_pkg::wb_t w_q;
    logic              mem_op;
    logic              wm_hit;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            m_q.valid <= 1'b0;
            m_q.ctrl  <= '0;
        end else begin
            m_q <= i_xm;
        end
    end

    assign mem_op = m_q.ctrl.is_load || m_q.ctrl.is_store;
    // store data produced by the instruction now in W
    assign wm_hit = w_q.we && (w_q.rd == m_q.rt);

    assign o_dmem_addr    = mem_op ? m_q.alu_out : '0;
    assign o_dmem_we      = m_q.ctrl.is_store;
    assign o_dmem_towrite = !m_q.ctrl.is_store ? '0 :
                            wm_hit ? w_q.data : m_q.store_val;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            w_q.valid <= 1'b0;
            w_q.we    <= 1'b0;
        end else begin
            w_q.valid <= m_q.valid;
            w_q.we    <= m_q.ctrl.rd_we;
            w_q.rd    <= m_q.rd;
            w_q.data  <= m_q.ctrl.is_load ? i_dmem_data : m_q.alu_out;
            w_q.pc    <= m_q.pc;
        end
    end

    assign o_mem         = m_q;
    assign o_wb          = w_q;
    assign o_load_nzp_we = m_q.ctrl.is_load;
    assign o_load_data   = i_dmem_data;

endmodule

//--- hw/lc4_core.sv
//////////////////////////////////////////////////
// lc4 five-stage pipelined core
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_core #(
    parameter lc4_pipe_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic                   gwe,
    input  logic                   i_reset,
    output lc4_pipe_pkg::word_t    o_cur_pc,
    input  lc4_pipe_pkg::word_t    i_cur_insn,
    output lc4_pipe_pkg::word_t    o_dmem_addr,
    output logic                   o_dmem_we,
    output lc4_pipe_pkg::word_t    o_dmem_towrite,
    input  lc4_pipe_pkg::word_t    i_dmem_data,
    output logic                   o_wb_valid,
    output logic                   o_wb_we,
    output lc4_pipe_pkg::reg_idx_t o_wb_reg,
    output lc4_pipe_pkg::word_t    o_wb_data,
    output lc4_pipe_pkg::word_t    o_wb_pc
);

    logic                   stall;
    logic                   redirect;
    lc4_pipe_pkg::word_t    target;
    lc4_pipe_pkg::reg_idx_t rs_idx;
    lc4_pipe_pkg::reg_idx_t rt_idx;
    lc4_pipe_pkg::word_t    rs_val;
    lc4_pipe_pkg::word_t    rt_val;
    lc4_pipe_pkg::dx_t      dx;
    lc4_pipe_pkg::xm_t      xm;
    lc4_pipe_pkg::xm_t      mem;
    lc4_pipe_pkg::wb_t      wb;
    logic                   ex_is_load;
    lc4_pipe_pkg::reg_idx_t ex_rd;
    logic                   load_nzp_we;
    lc4_pipe_pkg::word_t    load_data;

    lc4_fetch #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .gwe        (gwe),
        .i_reset    (i_reset),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .o_pc       (o_cur_pc)
    );

    lc4_decode decode_i (
        .gwe          (gwe),
        .i_reset      (i_reset),
        .i_pc         (o_cur_pc),
        .i_insn       (i_cur_insn),
        .i_flush      (redirect),
        .i_ex_is_load (ex_is_load),
        .i_ex_rd      (ex_rd),
        .o_stall      (stall),
        .o_rs_idx     (rs_idx),
        .o_rt_idx     (rt_idx),
        .i_rs_val     (rs_val),
        .i_rt_val     (rt_val),
        .o_dx         (dx)
    );

    lc4_regfile regfile_i (
        .gwe      (gwe),
        .i_reset  (i_reset),
        .i_rs_idx (rs_idx),
        .i_rt_idx (rt_idx),
        .o_rs_val (rs_val),
        .o_rt_val (rt_val),
        .i_wb     (wb)
    );

    lc4_execute execute_i (
        .gwe           (gwe),
        .i_reset       (i_reset),
        .i_dx          (dx),
        .i_mem         (mem),
        .i_wb          (wb),
        .i_load_nzp_we (load_nzp_we),
        .i_load_data   (load_data),
        .o_xm          (xm),
        .o_redirect    (redirect),
        .o_target      (target),
        .o_ex_is_load  (ex_is_load),
        .o_ex_rd       (ex_rd)
    );

    lc4_mem_wb mem_wb_i (
        .gwe            (gwe),
        .i_reset        (i_reset),
        .i_xm           (xm),
        .o_mem          (mem),
        .i_dmem_data    (i_dmem_data),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_we      (o_dmem_we),
        .o_dmem_towrite (o_dmem_towrite),
        .o_load_nzp_we  (load_nzp_we),
        .o_load_data    (load_data),
        .o_wb           (wb)
    );

    // writeback trace
    assign o_wb_valid = wb.valid;
    assign o_wb_we    = wb.we;
    assign o_wb_reg   = wb.rd;
    assign o_wb_data  = wb.data;
    assign o_wb_pc    = wb.pc;

endmodule

//--- tb/tb_clock_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset source
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic o_gwe,
    output logic o_reset
);

    initial begin
        o_gwe = 1'b0;
        forever begin
            #HALF_PERIOD o_gwe = ~o_gwe;
        end
    end

    // reset drops on a falling edge, like the other inputs
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge o_gwe);
        end
        @(negedge o_gwe);
        o_reset = 1'b0;
    end

endmodule

//--- tb/lc4_core_tb.sv
//////////////////////////////////////////////////
// lc4 core testbench
// runs a fixed program, checks writeback trace and stores
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lc4_core_tb;

    localparam logic [15:0] RESET_PC       = 16'h8200;
    localparam int          NUM_ROWS       = 24;
    localparam int          TIMEOUT_CYCLES = (NUM_ROWS + 10) * 3;

    typedef enum logic [1:0] {
        KIND_WRITE,
        KIND_STORE,
        KIND_NONE,
        KIND_SKIP
    } kind_t;

    // value is the register result for writes and the data for stores
    typedef struct {
        string       name;
        logic [15:0] insn;
        kind_t       kind;
        logic [2:0]  rd;
        logic [15:0] value;
        logic [15:0] addr;
    } row_t;

    logic        gwe;
    logic        reset;
    logic [15:0] cur_pc;
    logic [15:0] cur_insn = 16'h0000;
    logic [15:0] dmem_addr;
    logic        dmem_we;
    logic [15:0] dmem_towrite;
    logic [15:0] dmem_data = 16'h0000;
    logic        wb_valid;
    logic        wb_we;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic [15:0] wb_pc;

    row_t rows [NUM_ROWS];
    int   trace_rows [$];
    int   store_rows [$];
    int   cycle_count = 0;

    tb_clock_gen #(
        .HALF_PERIOD  (5),
        .RESET_CYCLES (5)
    ) clock_gen_i (
        .o_gwe   (gwe),
        .o_reset (reset)
    );

    lc4_core #(
        .RESET_PC(RESET_PC)
    ) lc4_core_i (
        .gwe            (gwe),
        .i_reset        (reset),
        .o_cur_pc       (cur_pc),
        .i_cur_insn     (cur_insn),
        .o_dmem_addr    (dmem_addr),
        .o_dmem_we      (dmem_we),
        .o_dmem_towrite (dmem_towrite),
        .i_dmem_data    (dmem_data),
        .o_wb_valid     (wb_valid),
        .o_wb_we        (wb_we),
        .o_wb_reg       (wb_reg),
        .o_wb_data      (wb_data),
        .o_wb_pc        (wb_pc)
    );

    function automatic logic [15:0] const_insn(input logic [2:0] rd, input logic [8:0] imm9);
        return {4'b1001, rd, imm9};
    endfunction

    function automatic logic [15:0] add_insn(input logic [2:0] rd, input logic [2:0] rs,
                                             input logic [2:0] rt);
        return {4'b0001, rd, rs, 3'b000, rt};
    endfunction

    function automatic logic [15:0] sub_insn(input logic [2:0] rd, input logic [2:0] rs,
                                             input logic [2:0] rt);
        return {4'b0001, rd, rs, 3'b010, rt};
    endfunction

    function automatic logic [15:0] addi_insn(input logic [2:0] rd, input logic [2:0] rs,
                                              input logic [4:0] imm5);
        return {4'b0001, rd, rs, 1'b1, imm5};
    endfunction

    function automatic logic [15:0] ldr_insn(input logic [2:0] rd, input logic [2:0] rs,
                                             input logic [5:0] imm6);
        return {4'b0110, rd, rs, imm6};
    endfunction

    function automatic logic [15:0] str_insn(input logic [2:0] rt, input logic [2:0] rs,
                                             input logic [5:0] imm6);
        return {4'b0111, rt, rs, imm6};
    endfunction

    function automatic logic [15:0] br_insn(input logic [2:0] nzp, input logic [8:0] imm9);
        return {4'b0000, nzp, imm9};
    endfunction

    // words outside the program read as a never-taken BR
    function automatic logic [15:0] fetch_word(input logic [15:0] pc);
        int offset;
        offset = int'(pc) - int'(RESET_PC);
        if (offset >= 0 && offset < NUM_ROWS) begin
            return rows[offset].insn;
        end
        return 16'h0000;
    endfunction

    task automatic set_row(input int idx, input string name, input logic [15:0] insn,
                           input kind_t kind, input logic [2:0] rd, input logic [15:0] value,
                           input logic [15:0] addr);
        rows[idx].name  = name;
        rows[idx].insn  = insn;
        rows[idx].kind  = kind;
        rows[idx].rd    = rd;
        rows[idx].value = value;
        rows[idx].addr  = addr;
    endtask

    // loads read addr ^ 16'h5a5a and a branch goes to pc + 1 + imm9
    task automatic load_program();
        set_row(0, "const r1 5", const_insn(3'd1, 9'h005), KIND_WRITE, 3'd1, 16'h0005, 16'h0);
        set_row(1, "const r2 -3", const_insn(3'd2, 9'h1fd), KIND_WRITE, 3'd2, 16'hfffd, 16'h0);
        set_row(2, "add r3 wx mx", add_insn(3'd3, 3'd1, 3'd2), KIND_WRITE, 3'd3, 16'h0002, 16'h0);
        set_row(3, "addi r4 -4", addi_insn(3'd4, 3'd3, 5'h1c), KIND_WRITE, 3'd4, 16'hfffe, 16'h0);
        set_row(4, "sub r5", sub_insn(3'd5, 3'd4, 3'd1), KIND_WRITE, 3'd5, 16'hfff9, 16'h0);
        set_row(5, "addi r5 zero", addi_insn(3'd5, 3'd5, 5'h07), KIND_WRITE, 3'd5, 16'h0000, 16'h0);
        set_row(6, "br n not taken", br_insn(3'b100, 9'h002), KIND_NONE, 3'd0, 16'h0, 16'h0);
        set_row(7, "ldr r6", ldr_insn(3'd6, 3'd1, 6'h03), KIND_WRITE, 3'd6, 16'h5a52, 16'h0);
        set_row(8, "add r7 load use", add_insn(3'd7, 3'd6, 3'd1), KIND_WRITE, 3'd7, 16'h5a57,
                16'h0);
        set_row(9, "str r7 mx", str_insn(3'd7, 3'd0, 6'h10), KIND_STORE, 3'd7, 16'h5a57, 16'h0010);
        // the load sets n while the flags before it say p
        set_row(10, "ldr r2", ldr_insn(3'd2, 3'd4, 6'h00), KIND_WRITE, 3'd2, 16'ha5a4, 16'h0);
        set_row(11, "br p after load", br_insn(3'b001, 9'h001), KIND_NONE, 3'd0, 16'h0, 16'h0);
        set_row(12, "str r2", str_insn(3'd2, 3'd1, 6'h01), KIND_STORE, 3'd2, 16'ha5a4, 16'h0006);
        set_row(13, "ldr r3", ldr_insn(3'd3, 3'd0, 6'h0c), KIND_WRITE, 3'd3, 16'h5a56, 16'h0);
        set_row(14, "str r3 wm", str_insn(3'd3, 3'd1, 6'h3f), KIND_STORE, 3'd3, 16'h5a56, 16'h0004);
        set_row(15, "const r4 0", const_insn(3'd4, 9'h000), KIND_WRITE, 3'd4, 16'h0000, 16'h0);
        set_row(16, "br z taken", br_insn(3'b010, 9'h002), KIND_NONE, 3'd0, 16'h0, 16'h0);
        set_row(17, "const r5 skipped", const_insn(3'd5, 9'h0aa), KIND_SKIP, 3'd5, 16'h0, 16'h0);
        set_row(18, "add r6 skipped", add_insn(3'd6, 3'd6, 3'd6), KIND_SKIP, 3'd6, 16'h0, 16'h0);
        set_row(19, "addi r7 9", addi_insn(3'd7, 3'd4, 5'h09), KIND_WRITE, 3'd7, 16'h0009, 16'h0);
        set_row(20, "br p taken", br_insn(3'b001, 9'h001), KIND_NONE, 3'd0, 16'h0, 16'h0);
        set_row(21, "const r1 skipped", const_insn(3'd1, 9'h111), KIND_SKIP, 3'd1, 16'h0, 16'h0);
        set_row(22, "sub r1", sub_insn(3'd1, 3'd7, 3'd2), KIND_WRITE, 3'd1, 16'h5a65, 16'h0);
        set_row(23, "add r0", add_insn(3'd0, 3'd1, 3'd1), KIND_WRITE, 3'd0, 16'hb4ca, 16'h0);
    endtask

    // every row that is not skipped shows up on the trace in program order
    task automatic build_checklist();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].kind != KIND_SKIP) begin
                trace_rows.push_back(i);
            end
            if (rows[i].kind == KIND_STORE) begin
                store_rows.push_back(i);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_store();
        int r;
        if (store_rows.size() == 0) begin
            $display("store to address 0x%04h where the program has none", dmem_addr);
            $display("Simulation failed");
            $fatal(1, "unexpected store");
        end else begin
            r = store_rows.pop_front();
            check_value($sformatf("%s addr", rows[r].name), rows[r].addr, dmem_addr);
            check_value($sformatf("%s data", rows[r].name), rows[r].value, dmem_towrite);
        end
    endtask

    task automatic check_writeback();
        int          r;
        logic [15:0] exp_we;
        if (trace_rows.size() == 0) begin
            $display("writeback from pc 0x%04h after the last expected row", wb_pc);
            $display("Simulation failed");
            $fatal(1, "extra writeback");
        end else begin
            r = trace_rows.pop_front();
            exp_we = (rows[r].kind == KIND_WRITE) ? 16'h0001 : 16'h0000;
            check_value($sformatf("%s pc", rows[r].name), RESET_PC + 16'(r), wb_pc);
            check_value($sformatf("%s we", rows[r].name), exp_we, {15'd0, wb_we});
            if (rows[r].kind == KIND_WRITE) begin
                check_value($sformatf("%s reg", rows[r].name), {13'd0, rows[r].rd},
                            {13'd0, wb_reg});
                check_value($sformatf("%s data", rows[r].name), rows[r].value, wb_data);
            end
        end
    endtask

    // imem and dmem answer within the cycle
    always @(negedge gwe) begin
        cur_insn  <= fetch_word(cur_pc);
        dmem_data <= dmem_addr ^ 16'h5a5a;
    end

    always @(posedge gwe) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with the program unfinished", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        load_program();
        build_checklist();
        @(negedge reset);
        check_value("reset pc", RESET_PC, cur_pc);
        check_value("reset wb valid", 16'h0000, {15'd0, wb_valid});
        check_value("reset dmem we", 16'h0000, {15'd0, dmem_we});
        // outputs settle after the rising edge and are sampled on the falling one
        while (trace_rows.size() != 0 || store_rows.size() != 0) begin
            @(negedge gwe);
            if (dmem_we) begin
                check_store();
            end
            if (wb_valid) begin
                check_writeback();
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog.f
hw/lc4_isa_pkg.sv
hw/lc4_pipe_pkg.sv
hw/lc4_fetch.sv
hw/lc4_decode.sv
hw/lc4_regfile.sv
hw/lc4_execute.sv
hw/lc4_mem_wb.sv
hw/lc4_core.sv
tb/tb_clock_gen.sv
tb/lc4_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the lc4 core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module lc4_core_tb \
    -f verilog.f

./obj_dir/Vlc4_core_tb
